/* dual_decode.f */
src/decode_pkg.sv
src/skid_buffer.sv
src/imm_gen.sv
src/slot_decoder.sv
src/dual_decode.sv
bench/tb_dual_decode.sv

/* Bender.yml */
package:
  name: dual_decode

sources:
  - src/decode_pkg.sv
  - src/skid_buffer.sv
  - src/imm_gen.sv
  - src/slot_decoder.sv
  - src/dual_decode.sv
  - target: test
    files:
      - bench/tb_dual_decode.sv

/* bench/tb_dual_decode.sv */
module tb_dual_decode;
    timeunit 1ns;
    timeprecision 100ps;
    import decode_pkg::*;

    // One rename-side transfer with both micro-ops, pc and slot-1 valid
    typedef struct packed {
        uop_t               u0;
        uop_t               u1;
        logic               ins1_valid;
        logic [PC_BITS-1:0] pc;
    } exp_t;

    localparam int unsigned N_DIR = 36;
    // Legal encodings first (0 to 19) and then one per illegal rule
    localparam logic [31:0] DIR_LIST [N_DIR] = '{
        32'hFFB10093, 32'h00532A23, 32'hFE208CE3, 32'h123451B7, 32'hFFFFF217,
        32'hFFDFF0EF, 32'h00008067, 32'hFFC42383, 32'h402081B3, 32'h407352B3,
        32'h4030D093, 32'h00309093, 32'h0FF0000F, 32'h0000100F, 32'h300312F3,
        32'h30002073, 32'h00000073, 32'h00100073, 32'h30200073, 32'h10500073,
        32'hFFB10090, 32'h0000002B, 32'h00013083, 32'h00016083, 32'h00017083,
        32'h00113023, 32'h00002063, 32'h00003063, 32'h00009067, 32'h02208133,
        32'h40209133, 32'h40309093, 32'h0230D093, 32'h00200073, 32'h00004073,
        32'h0000200F
    };
    localparam logic [4:0] OPC_POOL [11] = '{
        OPC_LOAD, OPC_STORE, OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
        OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_MISC_MEM, OPC_SYSTEM
    };

    logic                cpu_clk_i;
    logic                rst_n_i;
    logic                flush_i;
    fetch_bundle_t       fetch_bundle_i;
    logic                fetch_valid_i;
    logic                busy_o;
    priv_ctrl_t          priv_i;
    logic                rn_busy_i;
    logic                valid_o;
    uop_t                uop0_o;
    uop_t                uop1_o;
    logic                ins1_valid_o;
    logic [PC_BITS-1:0]  pc_o;

    integer              seed;
    int                  value_errors;
    int                  protocol_errors;
    int                  timeouts;
    logic [PC_BITS-1:0]  pc_cnt;
    exp_t                sb_q[$];
    exp_t                exp_head;
    exp_t                obs;
    int                  sb_count;

    dual_decode i_dual_decode (
        .cpu_clk_i      (cpu_clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .fetch_bundle_i (fetch_bundle_i),
        .fetch_valid_i  (fetch_valid_i),
        .busy_o         (busy_o),
        .priv_i         (priv_i),
        .rn_busy_i      (rn_busy_i),
        .valid_o        (valid_o),
        .uop0_o         (uop0_o),
        .uop1_o         (uop1_o),
        .ins1_valid_o   (ins1_valid_o),
        .pc_o           (pc_o)
    );

    always #4 cpu_clk_i = ~cpu_clk_i;

    assign obs = {uop0_o, uop1_o, ins1_valid_o, pc_o};

    task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("Error %s: expected %h, got %h", name, exp, act);
        value_errors++;
    endtask

    task automatic protocol_error(input string msg);
        $display("Protocol failure: %s", msg);
        protocol_errors++;
    endtask

    task automatic timeout_error(input string msg);
        $display("Timeout: %s", msg);
        timeouts++;
    endtask

    // Expected micro-op from the RV32I encoding rules
    task automatic model_uop(input logic [31:0] ins, input priv_ctrl_t priv,
                             input logic fx_v, input logic [3:0] fx_code, output uop_t u);
        logic [4:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        legal;
        logic        dest;
        logic        ecall;
        logic        ebreak;
        logic        mret;
        logic        wfi;
        logic        priv_bad;
        exec_class_e cls;
        opc    = ins[6:2];
        f3     = ins[14:12];
        f7     = ins[31:25];
        ecall  = ({ins[31:2], 2'b11} == 32'h00000073);
        ebreak = ({ins[31:2], 2'b11} == 32'h00100073);
        mret   = ({ins[31:2], 2'b11} == 32'h30200073);
        wfi    = ({ins[31:2], 2'b11} == 32'h10500073);
        u          = '0;
        u.rs1      = ins[19:15];
        u.rs2      = ins[24:20];
        u.rd       = ins[11:7];
        u.sub_op   = {1'b0, f3};
        u.uses_imm = opc inside {OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                                 OPC_JAL, OPC_JALR, OPC_BRANCH};
        dest = (opc inside {OPC_LOAD, OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL,
                            OPC_JALR}) || (opc == OPC_SYSTEM && f3 != 3'd0);
        case (opc)
            OPC_OP_IMM, OPC_JALR, OPC_LOAD, OPC_SYSTEM: u.imm = {{20{ins[31]}}, ins[31:20]};
            OPC_STORE:  u.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            OPC_BRANCH: u.imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC: u.imm = {ins[31:12], 12'h000};
            OPC_JAL:    u.imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            default:    u.imm = '0;
        endcase
        legal = 1'b1;
        cls   = CLS_NONE;
        case (opc)
            OPC_LOAD: begin
                cls   = CLS_LOAD;
                legal = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            end
            OPC_STORE: begin
                cls   = CLS_STORE;
                legal = (f3 <= 3'd2);
            end
            OPC_BRANCH: begin
                cls   = CLS_BRANCH;
                legal = !(f3 inside {3'd2, 3'd3});
            end
            OPC_JAL: begin
                cls      = CLS_BRANCH;
                u.sub_op = SUB_JAL;
            end
            OPC_JALR: begin
                cls      = CLS_BRANCH;
                u.sub_op = SUB_JALR;
                legal    = (f3 == 3'd0);
            end
            OPC_LUI: begin
                cls      = CLS_ALU;
                u.sub_op = SUB_LUI;
            end
            OPC_AUIPC: begin
                cls      = CLS_ALU;
                u.sub_op = SUB_AUIPC;
            end
            OPC_OP: begin
                cls      = CLS_ALU;
                u.sub_op = {ins[30], f3};
                legal    = (f7 == 7'h00) || (f7 == 7'h20 && f3 inside {3'd0, 3'd5});
            end
            OPC_OP_IMM: begin
                cls = CLS_ALU;
                // Only shifts carry funct7
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    u.sub_op = {ins[30], f3};
                    legal    = (f7 == 7'h00) || (f3 == 3'd5 && f7 == 7'h20);
                end
            end
            OPC_MISC_MEM: begin
                legal = (f3 <= 3'd1);
                if (f3 == 3'd0) begin
                    cls = CLS_FENCE;
                end else if (f3 == 3'd1) begin
                    cls = CLS_FENCE_I;
                end
            end
            OPC_SYSTEM: begin
                if (f3 != 3'd0) begin
                    cls   = CLS_CSR;
                    legal = (f3 != 3'd4);
                end else begin
                    cls   = CLS_SYSTEM;
                    legal = ecall || ebreak || mret || wfi;
                    if (ebreak) u.sub_op = SUB_EBREAK;
                    if (mret) u.sub_op = SUB_MRET;
                    if (wfi) u.sub_op = SUB_WFI;
                end
            end
            default: legal = 1'b0;
        endcase
        legal       = legal && (ins[1:0] == 2'b11);
        priv_bad    = (mret && !priv.machine_mode) ||
                      (wfi && !priv.machine_mode && priv.trap_wfi);
        u.cls       = legal ? cls : CLS_NONE;
        u.writes_rd = dest && legal && (u.rd != '0);
        u.excp_valid = 1'b1;
        if (fx_v) begin
            u.excp_code = excp_code_e'(fx_code);
        end else if (!legal || priv_bad) begin
            u.excp_code = EXC_ILLEGAL;
        end else if (ecall) begin
            u.excp_code = priv.machine_mode ? EXC_ECALL_M : EXC_ECALL_U;
        end else if (ebreak) begin
            u.excp_code = EXC_BREAKPOINT;
        end else begin
            u.excp_valid = 1'b0;
            u.excp_code  = excp_code_e'(4'd0);
        end
    endtask

    // Scoreboard pops on every transfer to rename and pushes on every accepted bundle
    always @(posedge cpu_clk_i) begin
        exp_t e;
        if (!rst_n_i) begin
            sb_q.delete();
        end else begin
            if (valid_o && !rn_busy_i && sb_q.size() != 0) begin
                void'(sb_q.pop_front());
            end
            if (flush_i) begin
                sb_q.delete();
            end else if (fetch_valid_i && !busy_o) begin
                model_uop(fetch_bundle_i.ins0, priv_i, fetch_bundle_i.fetch_excp_valid,
                          fetch_bundle_i.fetch_excp_code, e.u0);
                model_uop(fetch_bundle_i.ins1, priv_i, fetch_bundle_i.fetch_excp_valid,
                          fetch_bundle_i.fetch_excp_code, e.u1);
                e.ins1_valid = fetch_bundle_i.ins1_valid;
                e.pc         = fetch_bundle_i.pc;
                sb_q.push_back(e);
            end
        end
        sb_count = sb_q.size();
        exp_head = (sb_q.size() != 0) ? sb_q[0] : '0;
    end

    a_uop0: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        (valid_o && !rn_busy_i && sb_count != 0) |-> obs.u0 == exp_head.u0)
        else value_error("uop0_o", $sampled(exp_head.u0), $sampled(obs.u0));
    a_uop1: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        (valid_o && !rn_busy_i && sb_count != 0) |-> obs.u1 == exp_head.u1)
        else value_error("uop1_o", $sampled(exp_head.u1), $sampled(obs.u1));
    a_ins1v: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        (valid_o && !rn_busy_i && sb_count != 0) |-> obs.ins1_valid == exp_head.ins1_valid)
        else value_error("ins1_valid_o", $sampled(exp_head.ins1_valid),
                         $sampled(obs.ins1_valid));
    a_pc: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        (valid_o && !rn_busy_i && sb_count != 0) |-> obs.pc == exp_head.pc)
        else value_error("pc_o", $sampled(exp_head.pc), $sampled(obs.pc));
    a_no_extra: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        (valid_o && !rn_busy_i) |-> sb_count != 0)
        else protocol_error("valid_o high with no accepted bundle outstanding");
    a_hold_valid: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        (rn_busy_i && !flush_i) |=> $stable(valid_o))
        else protocol_error("valid_o changed while rename was busy");
    a_hold_data: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        (rn_busy_i && !flush_i && valid_o) |=> $stable(obs))
        else protocol_error("output payload changed while rename was busy");
    a_busy_empty: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        busy_o |-> sb_count != 0)
        else protocol_error("busy_o high while the stage is empty");
    a_latency: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        (fetch_valid_i && !busy_o && !flush_i && !rn_busy_i) |=> valid_o)
        else protocol_error("accepted bundle missing at the output one cycle later");
    a_flush: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        flush_i |=> !valid_o)
        else protocol_error("valid_o still high the cycle after flush");

    function automatic logic [31:0] rand_instr();
        logic [31:0] w;
        w = $random(seed);
        // Most words get a real major opcode so every decode path is hit
        if (w[31:29] != 3'b000) begin
            w[6:0] = {OPC_POOL[$unsigned($random(seed)) % 11], 2'b11};
        end
        return w;
    endfunction

    function automatic fetch_bundle_t rand_bundle();
        fetch_bundle_t b;
        b.pc               = 30'($random(seed));
        b.ins0             = rand_instr();
        b.ins1             = rand_instr();
        b.ins1_valid       = ($random(seed) & 1) != 0;
        b.fetch_excp_valid = ($random(seed) & 15) == 0;
        b.fetch_excp_code  = 4'($random(seed));
        return b;
    endfunction

    task automatic wait_empty();
        int n;
        n = 0;
        @(negedge cpu_clk_i);
        while ((sb_count != 0 || valid_o) && n < 50) begin
            @(negedge cpu_clk_i);
            n++;
        end
        if (sb_count != 0 || valid_o) timeout_error("stage did not drain");
    endtask

    // Present one bundle, hold it until taken, then let it drain
    task automatic send_bundle(input logic [31:0] i0, input logic [31:0] i1,
                               input logic fx_v, input priv_ctrl_t priv);
        fetch_bundle_t b;
        int            n;
        b.pc               = pc_cnt;
        b.ins0             = i0;
        b.ins1             = i1;
        b.ins1_valid       = pc_cnt[0];
        b.fetch_excp_valid = fx_v;
        b.fetch_excp_code  = fx_v ? 4'd12 : 4'd0;
        pc_cnt++;
        @(posedge cpu_clk_i);
        priv_i         <= priv;
        fetch_bundle_i <= b;
        fetch_valid_i  <= 1'b1;
        n = 0;
        @(posedge cpu_clk_i);
        while (busy_o && n < 20) begin
            @(posedge cpu_clk_i);
            n++;
        end
        if (busy_o) timeout_error("bundle was never accepted");
        fetch_valid_i <= 1'b0;
        wait_empty();
    endtask

    initial begin
        int         k;
        int         i;
        int         cyc;
        logic [1:0] p;
        seed            = 66146;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        pc_cnt          = 30'h100;
        cpu_clk_i       = 1'b0;
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        fetch_bundle_i  = '0;
        fetch_valid_i   = 1'b0;
        priv_i          = '0;
        rn_busy_i       = 1'b0;
        repeat (4) @(posedge cpu_clk_i);
        rst_n_i <= 1'b1;
        @(negedge cpu_clk_i);
        assert (!valid_o && !busy_o)
            else protocol_error("valid_o or busy_o high after reset");

        // Every directed word in both slots under all privilege settings
        for (k = 0; k < 4; k++) begin
            p = k[1:0];
            for (i = 0; i < N_DIR; i++) begin
                send_bundle(DIR_LIST[i], DIR_LIST[(i + 11) % N_DIR], 1'b0, priv_ctrl_t'(p));
            end
        end
        // Fetch fault must override whatever decode finds
        for (i = 0; i < N_DIR; i++) begin
            send_bundle(DIR_LIST[i], DIR_LIST[N_DIR - 1 - i], 1'b1, priv_ctrl_t'(2'b10));
        end

        // Random traffic with stalls and flushes
        for (cyc = 0; cyc < 600; cyc++) begin
            @(posedge cpu_clk_i);
            if (!fetch_valid_i || (!busy_o && !flush_i)) begin
                fetch_valid_i  <= ($random(seed) & 3) != 0;
                fetch_bundle_i <= rand_bundle();
            end
            rn_busy_i <= ($random(seed) & 7) < 3;
            flush_i   <= ($random(seed) & 31) == 0;
        end
        @(posedge cpu_clk_i);
        fetch_valid_i <= 1'b0;
        rn_busy_i     <= 1'b0;
        flush_i       <= 1'b0;
        wait_empty();

        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* src/dual_decode.sv */
module dual_decode (
    input  logic                            cpu_clk_i,
    input  logic                            rst_n_i,
    input  logic                            flush_i,

    // Fetch side
    input  decode_pkg::fetch_bundle_t       fetch_bundle_i,
    input  logic                            fetch_valid_i,
    output logic                            busy_o,

    input  decode_pkg::priv_ctrl_t          priv_i,

    // Rename side
    input  logic                            rn_busy_i,
    output logic                            valid_o,
    output decode_pkg::uop_t                uop0_o,
    output decode_pkg::uop_t                uop1_o,
    output logic                            ins1_valid_o,
    output logic [decode_pkg::PC_BITS-1:0]  pc_o
);
    import decode_pkg::*;

    localparam int unsigned BUNDLE_W = $bits(fetch_bundle_t);

    fetch_bundle_t buf_bundle;
    logic          buf_valid;
    uop_t          slot0_uop;
    uop_t          slot1_uop;

    // Holds the bundle while rename stalls
    skid_buffer #(
        .DATA_W (BUNDLE_W)
    ) i_skid_buffer (
        .cpu_clk_i (cpu_clk_i),
        .rst_n_i   (rst_n_i),
        .flush_i   (flush_i),
        .data_i    (fetch_bundle_i),
        .valid_i   (fetch_valid_i),
        .busy_o    (busy_o),
        .data_o    (buf_bundle),
        .valid_o   (buf_valid),
        .ready_i   (~rn_busy_i)
    );

    slot_decoder i_slot0 (
        .instr_i            (buf_bundle.ins0),
        .priv_i             (priv_i),
        .fetch_excp_valid_i (buf_bundle.fetch_excp_valid),
        .fetch_excp_code_i  (buf_bundle.fetch_excp_code),
        .uop_o              (slot0_uop)
    );

    // Same fetch fault reported in both slots
    slot_decoder i_slot1 (
        .instr_i            (buf_bundle.ins1),
        .priv_i             (priv_i),
        .fetch_excp_valid_i (buf_bundle.fetch_excp_valid),
        .fetch_excp_code_i  (buf_bundle.fetch_excp_code),
        .uop_o              (slot1_uop)
    );

    // Flush wins over a stall
    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (!rn_busy_i) begin
            valid_o <= buf_valid;
        end
    end

    // Payload only moves when rename takes it
    always_ff @(posedge cpu_clk_i) begin
        if (!rn_busy_i) begin
            uop0_o       <= slot0_uop;
            uop1_o       <= slot1_uop;
            ins1_valid_o <= buf_bundle.ins1_valid;
            pc_o         <= buf_bundle.pc;
        end
    end

endmodule

/* src/slot_decoder.sv */
module slot_decoder (
    input  logic [31:0]            instr_i,
    input  decode_pkg::priv_ctrl_t priv_i,
    input  logic                   fetch_excp_valid_i,
    input  logic [3:0]             fetch_excp_code_i,
    output decode_pkg::uop_t       uop_o
);
    import decode_pkg::*;

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;

    logic                  is_system;
    logic                  is_ecall;
    logic                  is_ebreak;
    logic                  is_mret;
    logic                  is_wfi;

    exec_class_e           cls_raw;
    logic [3:0]            sub_op;
    logic                  uses_imm;
    logic                  enc_legal;
    logic                  gpr_dest;
    logic                  illegal;
    logic                  priv_illegal;
    logic                  excp_valid;
    excp_code_e            excp_code;

    assign opcode = opcode_e'(instr_i[OPCODE_POS +: 5]);
    assign funct3 = instr_i[FUNCT3_POS +: 3];
    assign funct7 = instr_i[FUNCT7_POS +: 7];
    assign rd     = instr_i[RD_POS +: REG_ADDR_W];

    imm_gen i_imm_gen (
        .instr_i  (instr_i),
        .opcode_i (opcode),
        .imm_o    (imm)
    );

    // Fixed SYSTEM encodings including rd and rs1
    assign is_system = (opcode == OPC_SYSTEM);
    assign is_ecall  = is_system && (instr_i[31:7] == ENC_ECALL);
    assign is_ebreak = is_system && (instr_i[31:7] == ENC_EBREAK);
    assign is_mret   = is_system && (instr_i[31:7] == ENC_MRET);
    assign is_wfi    = is_system && (instr_i[31:7] == ENC_WFI);

    always_comb begin
        cls_raw   = CLS_NONE;
        sub_op    = {1'b0, funct3};
        uses_imm  = 1'b0;
        enc_legal = 1'b1;
        gpr_dest  = 1'b0;
        case (opcode)
            OPC_LOAD: begin
                cls_raw   = CLS_LOAD;
                uses_imm  = 1'b1;
                gpr_dest  = 1'b1;
                // LD and the whole 11x group are not RV32I loads
                enc_legal = (funct3 != 3'd3) && (funct3[2:1] != 2'b11);
            end
            OPC_STORE: begin
                cls_raw   = CLS_STORE;
                uses_imm  = 1'b1;
                enc_legal = (funct3 <= 3'd2);
            end
            OPC_OP: begin
                cls_raw   = CLS_ALU;
                sub_op    = {instr_i[30], funct3};
                gpr_dest  = 1'b1;
                enc_legal = (funct7 == 7'h00) ||
                            ((funct7 == 7'h20) && ((funct3 == 3'd0) || (funct3 == 3'd5)));
            end
            OPC_OP_IMM: begin
                cls_raw  = CLS_ALU;
                uses_imm = 1'b1;
                gpr_dest = 1'b1;
                // Bit 30 is immediate data except on shifts
                if (funct3 == 3'd1) begin
                    sub_op    = {instr_i[30], funct3};
                    enc_legal = (funct7 == 7'h00);
                end else if (funct3 == 3'd5) begin
                    sub_op    = {instr_i[30], funct3};
                    enc_legal = (funct7 == 7'h00) || (funct7 == 7'h20);
                end
            end
            OPC_LUI: begin
                cls_raw  = CLS_ALU;
                sub_op   = SUB_LUI;
                uses_imm = 1'b1;
                gpr_dest = 1'b1;
            end
            OPC_AUIPC: begin
                cls_raw  = CLS_ALU;
                sub_op   = SUB_AUIPC;
                uses_imm = 1'b1;
                gpr_dest = 1'b1;
            end
            OPC_JAL: begin
                cls_raw  = CLS_BRANCH;
                sub_op   = SUB_JAL;
                uses_imm = 1'b1;
                gpr_dest = 1'b1;
            end
            OPC_JALR: begin
                cls_raw   = CLS_BRANCH;
                sub_op    = SUB_JALR;
                uses_imm  = 1'b1;
                gpr_dest  = 1'b1;
                enc_legal = (funct3 == 3'd0);
            end
            OPC_BRANCH: begin
                cls_raw   = CLS_BRANCH;
                uses_imm  = 1'b1;
                // funct3 010 and 011 are reserved
                enc_legal = (funct3[2:1] != 2'b01);
            end
            OPC_MISC_MEM: begin
                if (funct3 == 3'd0) begin
                    cls_raw = CLS_FENCE;
                end else if (funct3 == 3'd1) begin
                    cls_raw = CLS_FENCE_I;
                end else begin
                    enc_legal = 1'b0;
                end
            end
            OPC_SYSTEM: begin
                if (funct3 != 3'd0) begin
                    cls_raw   = CLS_CSR;
                    gpr_dest  = 1'b1;
                    enc_legal = (funct3 != 3'd4);
                end else begin
                    cls_raw   = CLS_SYSTEM;
                    enc_legal = is_ecall | is_ebreak | is_mret | is_wfi;
                    if (is_ebreak) begin
                        sub_op = SUB_EBREAK;
                    end else if (is_mret) begin
                        sub_op = SUB_MRET;
                    end else if (is_wfi) begin
                        sub_op = SUB_WFI;
                    end else begin
                        sub_op = SUB_ECALL;
                    end
                end
            end
            default: begin
                enc_legal = 1'b0;
            end
        endcase
    end

    // 16-bit encodings are not supported
    assign illegal = ~enc_legal | (instr_i[1:0] != 2'b11);

    // MRET needs M-mode and WFI traps from U-mode when TW is set
    assign priv_illegal = (is_mret & ~priv_i.machine_mode) |
                          (is_wfi & ~priv_i.machine_mode & priv_i.trap_wfi);

    always_comb begin
        excp_valid = 1'b1;
        if (fetch_excp_valid_i) begin
            excp_code = excp_code_e'(fetch_excp_code_i);
        end else if (illegal | priv_illegal) begin
            excp_code = EXC_ILLEGAL;
        end else if (is_ecall) begin
            excp_code = priv_i.machine_mode ? EXC_ECALL_M : EXC_ECALL_U;
        end else if (is_ebreak) begin
            excp_code = EXC_BREAKPOINT;
        end else begin
            excp_valid = 1'b0;
            excp_code  = excp_code_e'(4'd0);
        end
    end

    always_comb begin
        uop_o.cls        = illegal ? CLS_NONE : cls_raw;
        uop_o.sub_op     = sub_op;
        uop_o.uses_imm   = uses_imm;
        uop_o.rs1        = instr_i[RS1_POS +: REG_ADDR_W];
        uop_o.rs2        = instr_i[RS2_POS +: REG_ADDR_W];
        uop_o.rd         = rd;
        uop_o.imm        = imm;
        uop_o.writes_rd  = gpr_dest & ~illegal & (rd != '0);
        uop_o.excp_valid = excp_valid;
        uop_o.excp_code  = excp_code;
    end

endmodule

/* src/imm_gen.sv */
module imm_gen (
    input  logic [31:0]         instr_i,
    input  decode_pkg::opcode_e opcode_i,
    output logic [31:0]         imm_o
);
    import decode_pkg::*;

    logic [XLEN-1:0] imm_i_fmt;
    logic [XLEN-1:0] imm_s_fmt;
    logic [XLEN-1:0] imm_b_fmt;
    logic [XLEN-1:0] imm_u_fmt;
    logic [XLEN-1:0] imm_j_fmt;

    assign imm_i_fmt = {{20{instr_i[31]}}, instr_i[31:20]};

    assign imm_s_fmt = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

    // Branch and jump offsets are in half-words with bit 0 always zero
    assign imm_b_fmt = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};

    assign imm_u_fmt = {instr_i[31:12], 12'h000};

    assign imm_j_fmt = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};

    always_comb begin
        case (opcode_i)
            // SYSTEM carries the CSR address in the I field
            OPC_OP_IMM,
            OPC_JALR,
            OPC_LOAD,
            OPC_SYSTEM: imm_o = imm_i_fmt;
            OPC_STORE:  imm_o = imm_s_fmt;
            OPC_BRANCH: imm_o = imm_b_fmt;
            OPC_LUI,
            OPC_AUIPC:  imm_o = imm_u_fmt;
            OPC_JAL:    imm_o = imm_j_fmt;
            default:    imm_o = '0;
        endcase
    end

endmodule

/* src/skid_buffer.sv */
module skid_buffer #(
    parameter int unsigned DATA_W = 32
) (
    input  logic              cpu_clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,

    // Upstream side
    input  logic [DATA_W-1:0] data_i,
    input  logic              valid_i,
    output logic              busy_o,

    // Downstream side
    output logic [DATA_W-1:0] data_o,
    output logic              valid_o,
    input  logic              ready_i
);

    logic              stored_valid_q;
    logic [DATA_W-1:0] stored_data_q;
    logic              accept;
    logic              capture;

    // New data is taken only while nothing is parked
    assign accept  = valid_i & ~stored_valid_q & ~flush_i;

    // Park the entry when downstream cannot take it this cycle
    assign capture = accept & ~ready_i;

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stored_valid_q <= 1'b0;
        end else if (flush_i) begin
            stored_valid_q <= 1'b0;
        end else if (capture) begin
            stored_valid_q <= 1'b1;
        end else if (ready_i) begin
            // Parked entry drained downstream
            stored_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (capture) begin
            stored_data_q <= data_i;
        end
    end

    // Upstream must hold its bundle while an entry is parked
    assign busy_o  = stored_valid_q;

    // Parked entry goes out before anything new
    assign data_o  = stored_valid_q ? stored_data_q : data_i;
    assign valid_o = stored_valid_q | accept;

endmodule

/* src/decode_pkg.sv */
package decode_pkg;

    // Widths shared by the decode stage
    localparam int unsigned XLEN       = 32;
    localparam int unsigned PC_BITS    = 30;
    localparam int unsigned REG_ADDR_W = 5;

    // Lowest bit of each RV32I instruction field
    localparam int unsigned OPCODE_POS = 2;
    localparam int unsigned RD_POS     = 7;
    localparam int unsigned FUNCT3_POS = 12;
    localparam int unsigned RS1_POS    = 15;
    localparam int unsigned RS2_POS    = 20;
    localparam int unsigned FUNCT7_POS = 25;

    // Bits 31 to 7 of the fixed SYSTEM encodings
    localparam logic [24:0] ENC_ECALL  = 25'h0000000;
    localparam logic [24:0] ENC_EBREAK = 25'h0002000;
    localparam logic [24:0] ENC_MRET   = 25'h0604000;
    localparam logic [24:0] ENC_WFI    = 25'h020A000;

    // Major opcodes, instruction bits 6 to 2
    typedef enum logic [4:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011,
        OPC_SYSTEM   = 5'b11100
    } opcode_e;

    // Unit that receives the micro-op
    typedef enum logic [3:0] {
        CLS_ALU     = 4'd0,
        CLS_BRANCH  = 4'd1,
        CLS_LOAD    = 4'd2,
        CLS_STORE   = 4'd3,
        CLS_CSR     = 4'd4,
        CLS_FENCE   = 4'd5,
        CLS_FENCE_I = 4'd6,
        CLS_SYSTEM  = 4'd7,
        CLS_NONE    = 4'd15
    } exec_class_e;

    // Machine cause codes raised by decode
    typedef enum logic [3:0] {
        EXC_ILLEGAL    = 4'd2,
        EXC_BREAKPOINT = 4'd3,
        EXC_ECALL_U    = 4'd8,
        EXC_ECALL_M    = 4'd11
    } excp_code_e;

    // Sub-ops with no funct3 of their own
    // ALU sub-ops {1,010} and {1,011} never occur for OP or OP-IMM
    localparam logic [3:0] SUB_LUI   = 4'b1010;
    localparam logic [3:0] SUB_AUIPC = 4'b1011;
    // Conditional branches keep {0,funct3} in the branch unit
    localparam logic [3:0] SUB_JAL   = 4'b1000;
    localparam logic [3:0] SUB_JALR  = 4'b1001;
    // SYSTEM class
    localparam logic [3:0] SUB_ECALL  = 4'd0;
    localparam logic [3:0] SUB_EBREAK = 4'd1;
    localparam logic [3:0] SUB_MRET   = 4'd2;
    localparam logic [3:0] SUB_WFI    = 4'd3;

    typedef struct packed {
        exec_class_e           cls;
        logic [3:0]            sub_op;
        logic                  uses_imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        logic                  writes_rd;
        logic                  excp_valid;
        excp_code_e            excp_code;
    } uop_t;

    typedef struct packed {
        logic [PC_BITS-1:0] pc;
        logic [31:0]        ins0;
        logic [31:0]        ins1;
        logic               ins1_valid;
        logic               fetch_excp_valid;
        logic [3:0]         fetch_excp_code;
    } fetch_bundle_t;

    typedef struct packed {
        logic machine_mode;
        logic trap_wfi;
    } priv_ctrl_t;

endpackage
